/* hw/bank_mapper.sv */
`default_nettype none

module bank_mapper (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     reload,
    input  msx_cart_pkg::cart_typ_t typ,
    input  wire                     map_wr,
    input  msx_cart_pkg::cpu_addr_t map_addr,
    input  msx_cart_pkg::cpu_data_t map_data,
    input  msx_cart_pkg::cpu_addr_t rd_addr,
    output msx_cart_pkg::rom_addr_t rom_offset
);

    msx_cart_pkg::bank_t bank [4];
    logic                wr_en;
    logic [1:0]          wr_sel;
    logic [1:0]          idx8;
    logic [1:0]          idx16;

    always_comb begin
        wr_en  = 1'b0;
        wr_sel = 2'd0;
        case (typ)
            msx_cart_pkg::CART_SCC: begin
                case (map_addr[15:11])
                    5'b01010: begin
                        wr_en  = 1'b1;
                        wr_sel = 2'd0;
                    end
                    5'b01110: begin
                        wr_en  = 1'b1;
                        wr_sel = 2'd1;
                    end
                    5'b10010: begin
                        wr_en  = 1'b1;
                        wr_sel = 2'd2;
                    end
                    5'b10110: begin
                        wr_en  = 1'b1;
                        wr_sel = 2'd3;
                    end
                    default:  wr_en = 1'b0;
                endcase
            end
            msx_cart_pkg::CART_ASCII8: begin
                wr_en  = map_addr[15:13] == 3'b011;   // 6000h to 7FFFh.
                wr_sel = map_addr[12:11];
            end
            msx_cart_pkg::CART_ASCII16: begin
                wr_en  = map_addr[15:11] == 5'b01100 || map_addr[15:11] == 5'b01110;
                wr_sel = {1'b0, map_addr[12]};
            end
            default: wr_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || reload) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= msx_cart_pkg::bank_t'(i);
            end
        end else if (map_wr && wr_en) begin
            bank[wr_sel] <= map_data;
        end
    end

    // 8K pages start at 4000h, so page 2 of the address selects bank 0.
    assign idx8  = 2'(rd_addr[15:13] - 3'd2);
    assign idx16 = rd_addr[15:14] - 2'd1;

    always_comb begin
        case (typ)
            msx_cart_pkg::CART_SCC, msx_cart_pkg::CART_ASCII8: begin
                rom_offset = msx_cart_pkg::rom_addr_t'({bank[idx8][6:0], rd_addr[12:0]});
            end
            msx_cart_pkg::CART_ASCII16: begin
                rom_offset = msx_cart_pkg::rom_addr_t'({bank[idx16][5:0], rd_addr[13:0]});
            end
            default: begin
                rom_offset = msx_cart_pkg::rom_addr_t'(rd_addr - 16'h4000);
            end
        endcase
    end

    // the slot controller holds bank writes while a new type is taking over.
    a_no_wr_on_type_change: assert property (@(posedge clk) disable iff (rst)
        (reload && typ != $past(typ)) |-> !map_wr)
        else $error("bank write during reload with a changed cartridge type");

endmodule

`default_nettype wire

/* hw/cart_config.sv */
`default_nettype none

module cart_config (
    input  wire                     clk,
    input  wire                     rst,
    input  msx_cart_pkg::status_t   status,
    input  wire                     disable_fdc,
    output msx_cart_pkg::slot_cfg_t slot_cfg,
    output logic                    rom_a_load_hide,
    output logic                    rom_b_load_hide,
    output logic                    reload
);

    logic [3:0]              sel_a;
    logic [3:0]              sel_b;
    msx_cart_pkg::slot_cfg_t last_cfg;

    assign sel_a = status[msx_cart_pkg::SLOT_A_LSB +: 4];
    assign sel_b = status[msx_cart_pkg::SLOT_B_LSB +: 4];

    always_comb begin
        case (sel_a)
            4'd0:    slot_cfg.typ_a = msx_cart_pkg::CART_ROM;
            4'd1:    slot_cfg.typ_a = msx_cart_pkg::CART_SCC;
            4'd2:    slot_cfg.typ_a = msx_cart_pkg::CART_ASCII8;
            4'd3:    slot_cfg.typ_a = msx_cart_pkg::CART_ASCII16;
            default: slot_cfg.typ_a = msx_cart_pkg::CART_EMPTY;
        endcase
    end

    // slot 2 defaults to the disk interface unless the menu turns it off.
    always_comb begin
        case (sel_b)
            4'd0: begin
                if (disable_fdc) begin
                    slot_cfg.typ_b = msx_cart_pkg::CART_EMPTY;
                end else begin
                    slot_cfg.typ_b = msx_cart_pkg::CART_FDC;
                end
            end
            4'd1:    slot_cfg.typ_b = msx_cart_pkg::CART_ROM;
            4'd2:    slot_cfg.typ_b = msx_cart_pkg::CART_SCC;
            4'd3:    slot_cfg.typ_b = msx_cart_pkg::CART_ASCII8;
            4'd4:    slot_cfg.typ_b = msx_cart_pkg::CART_ASCII16;
            default: slot_cfg.typ_b = msx_cart_pkg::CART_EMPTY;
        endcase
    end

    assign rom_a_load_hide = slot_cfg.typ_a != msx_cart_pkg::CART_ROM;
    assign rom_b_load_hide = slot_cfg.typ_b != msx_cart_pkg::CART_ROM;

    // the copy follows during reset, so no pulse fires when reset drops.
    always_ff @(posedge clk) begin
        if (rst || reload) begin
            last_cfg <= slot_cfg;
        end
    end

    assign reload = !rst && (slot_cfg != last_cfg); // one cycle, the copy catches up.

endmodule

`default_nettype wire

/* hw/msx_cart_pkg.sv */
`default_nettype none

package msx_cart_pkg;

    localparam int SLOT_A_LSB   = 17;
    localparam int SLOT_B_LSB   = 29;
    localparam int HOST_CREDITS = 2;
    localparam int MEM_CREDITS  = 4;
    localparam int RSP_DEPTH    = 8;

    localparam int HOST_AW = $clog2(HOST_CREDITS);
    localparam int HOST_CW = $clog2(HOST_CREDITS + 1);
    localparam int MEM_CW  = $clog2(MEM_CREDITS + 1);
    localparam int RSP_AW  = $clog2(RSP_DEPTH);
    localparam int RSP_CW  = $clog2(RSP_DEPTH + 1);

    typedef logic [63:0] status_t;
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [20:0] rom_addr_t;
    typedef logic [7:0]  bank_t;

    typedef logic [HOST_AW-1:0] host_ptr_t;
    typedef logic [HOST_CW-1:0] host_cnt_t;
    typedef logic [MEM_CW-1:0]  mem_cnt_t;
    typedef logic [RSP_AW-1:0]  rsp_ptr_t;
    typedef logic [RSP_CW-1:0]  rsp_cnt_t;

    localparam rom_addr_t SLOT_SPAN = rom_addr_t'(2 ** 20); // slot 2 starts at 1 MB.
    localparam cpu_data_t OPEN_BUS  = 8'hFF;

    typedef enum logic [2:0] {
        CART_ROM     = 3'd0,
        CART_SCC     = 3'd1,
        CART_ASCII8  = 3'd2,
        CART_ASCII16 = 3'd3,
        CART_FDC     = 3'd4,
        CART_EMPTY   = 3'd5
    } cart_typ_t;

    typedef struct packed {
        logic      wr;
        logic      slot;    // 0 is slot 1, 1 is slot 2.
        cpu_addr_t addr;
        cpu_data_t data;
    } host_req_t;

    typedef struct packed {
        rom_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        cart_typ_t typ_b;
        cart_typ_t typ_a;
    } slot_cfg_t;

    typedef struct packed {
        cpu_data_t data;
    } host_rsp_t;

endpackage

`default_nettype wire

/* hw/msx_cart_top.sv */
`default_nettype none

module msx_cart_top (
    input  wire                     clk,
    input  wire                     rst,
    input  msx_cart_pkg::status_t   status,
    input  wire                     disable_fdc,
    input  wire                     host_req_valid,
    input  msx_cart_pkg::host_req_t host_req,
    output logic                    host_credit,
    output logic                    rsp_valid,
    output msx_cart_pkg::host_rsp_t rsp,
    input  wire                     rsp_ready,
    output logic                    mem_req_valid,
    output msx_cart_pkg::mem_req_t  mem_req,
    input  wire                     mem_credit,
    input  wire                     mem_rsp_valid,
    input  msx_cart_pkg::cpu_data_t mem_rsp_data,
    output logic                    rom_a_load_hide,
    output logic                    rom_b_load_hide,
    output logic                    reload
);

    msx_cart_pkg::slot_cfg_t slot_cfg;
    msx_cart_pkg::cpu_addr_t map_addr;
    msx_cart_pkg::cpu_data_t map_data;
    msx_cart_pkg::rom_addr_t rom_offset_a;
    msx_cart_pkg::rom_addr_t rom_offset_b;
    msx_cart_pkg::cpu_data_t rsv_data;
    logic                    map_wr_a;
    logic                    map_wr_b;
    logic                    rsv_valid;
    logic                    rsv_imm;
    logic                    rsv_space;

    cart_config i_cart_config (
        .clk, .rst, .status, .disable_fdc, .slot_cfg,
        .rom_a_load_hide, .rom_b_load_hide, .reload
    );

    slot_ctrl i_slot_ctrl (
        .clk, .rst, .host_req_valid, .host_req, .host_credit, .slot_cfg, .reload,
        .map_wr_a, .map_wr_b, .map_addr, .map_data, .rom_offset_a, .rom_offset_b,
        .mem_req_valid, .mem_req, .mem_credit, .rsv_valid, .rsv_imm, .rsv_data, .rsv_space
    );

    // both mappers translate the address at the head of the intake.
    bank_mapper i_mapper_a (
        .clk, .rst, .reload, .typ(slot_cfg.typ_a), .map_wr(map_wr_a),
        .map_addr, .map_data, .rd_addr(map_addr), .rom_offset(rom_offset_a)
    );

    bank_mapper i_mapper_b (
        .clk, .rst, .reload, .typ(slot_cfg.typ_b), .map_wr(map_wr_b),
        .map_addr, .map_data, .rd_addr(map_addr), .rom_offset(rom_offset_b)
    );

    resp_buffer i_resp_buffer (
        .clk, .rst, .rsv_valid, .rsv_imm, .rsv_data, .rsv_space,
        .mem_rsp_valid, .mem_rsp_data, .rsp_valid, .rsp, .rsp_ready
    );

endmodule

`default_nettype wire

/* hw/resp_buffer.sv */
`default_nettype none

module resp_buffer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     rsv_valid,
    input  wire                     rsv_imm,
    input  msx_cart_pkg::cpu_data_t rsv_data,
    output logic                    rsv_space,
    input  wire                     mem_rsp_valid,
    input  msx_cart_pkg::cpu_data_t mem_rsp_data,
    output logic                    rsp_valid,
    output msx_cart_pkg::host_rsp_t rsp,
    input  wire                     rsp_ready
);

    msx_cart_pkg::cpu_data_t         data [msx_cart_pkg::RSP_DEPTH];
    logic [msx_cart_pkg::RSP_DEPTH-1:0] filled;
    msx_cart_pkg::rsp_ptr_t          rsv_ptr;
    msx_cart_pkg::rsp_ptr_t          fill_ptr;
    msx_cart_pkg::rsp_ptr_t          fill_idx;
    msx_cart_pkg::rsp_ptr_t          head_ptr;
    msx_cart_pkg::rsp_cnt_t          count;
    logic                            fill_found;
    logic                            pop;

    // oldest entry still waiting for memory data, searched from the fill pointer.
    always_comb begin
        fill_found = 1'b0;
        fill_idx   = fill_ptr;
        for (int i = 0; i < msx_cart_pkg::RSP_DEPTH; i++) begin
            if (!fill_found && !filled[msx_cart_pkg::rsp_ptr_t'(fill_ptr + i)]) begin
                fill_found = 1'b1;
                fill_idx   = msx_cart_pkg::rsp_ptr_t'(fill_ptr + i);
            end
        end
    end

    assign rsv_space = count < msx_cart_pkg::rsp_cnt_t'(msx_cart_pkg::RSP_DEPTH);
    assign rsp_valid = count != '0 && filled[head_ptr];
    assign rsp.data  = data[head_ptr];
    assign pop       = rsp_valid && rsp_ready;

    always_ff @(posedge clk) begin
        if (rsv_valid && rsv_imm) begin
            data[rsv_ptr] <= rsv_data;
        end
        if (mem_rsp_valid) begin
            data[fill_idx] <= mem_rsp_data;
        end
    end

    // free entries stay marked filled, so the search only finds pending ones.
    always_ff @(posedge clk) begin
        if (rst) begin
            filled   <= '1;
            rsv_ptr  <= '0;
            fill_ptr <= '0;
            head_ptr <= '0;
            count    <= '0;
        end else begin
            if (rsv_valid) begin
                filled[rsv_ptr] <= rsv_imm;
                rsv_ptr         <= rsv_ptr + 1'b1;
            end
            if (mem_rsp_valid) begin
                filled[fill_idx] <= 1'b1;
                fill_ptr         <= fill_idx + 1'b1;
            end
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            count <= count + msx_cart_pkg::rsp_cnt_t'(rsv_valid) - msx_cart_pkg::rsp_cnt_t'(pop);
        end
    end

    a_no_orphan_rsp: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> fill_found)
        else $error("memory response with no pending entry");

endmodule

`default_nettype wire

/* hw/slot_ctrl.sv */
`default_nettype none

module slot_ctrl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     host_req_valid,
    input  msx_cart_pkg::host_req_t host_req,
    output logic                    host_credit,
    input  msx_cart_pkg::slot_cfg_t slot_cfg,
    input  wire                     reload,
    output logic                    map_wr_a,
    output logic                    map_wr_b,
    output msx_cart_pkg::cpu_addr_t map_addr,
    output msx_cart_pkg::cpu_data_t map_data,
    input  msx_cart_pkg::rom_addr_t rom_offset_a,
    input  msx_cart_pkg::rom_addr_t rom_offset_b,
    output logic                    mem_req_valid,
    output msx_cart_pkg::mem_req_t  mem_req,
    input  wire                     mem_credit,
    output logic                    rsv_valid,
    output logic                    rsv_imm,
    output msx_cart_pkg::cpu_data_t rsv_data,
    input  wire                     rsv_space
);

    typedef enum logic {
        IDLE,
        ISSUE
    } state_t;

    msx_cart_pkg::host_req_t fifo [msx_cart_pkg::HOST_CREDITS];
    msx_cart_pkg::host_ptr_t wr_ptr;
    msx_cart_pkg::host_ptr_t rd_ptr;
    msx_cart_pkg::host_cnt_t fifo_cnt;
    msx_cart_pkg::host_cnt_t fifo_cnt_next;
    msx_cart_pkg::mem_cnt_t  mem_cnt;
    msx_cart_pkg::host_req_t head;
    msx_cart_pkg::cart_typ_t head_typ;
    msx_cart_pkg::rom_addr_t head_offset;
    state_t                  state;
    logic                    in_window;
    logic                    imm;
    logic                    do_write;
    logic                    do_read;
    logic                    pop;

    always_ff @(posedge clk) begin
        if (host_req_valid) begin
            fifo[wr_ptr] <= host_req;
        end
    end

    assign head        = fifo[rd_ptr];
    assign head_typ    = head.slot ? slot_cfg.typ_b : slot_cfg.typ_a;
    assign head_offset = head.slot ? rom_offset_b : rom_offset_a;
    assign in_window   = head.addr[15:14] == 2'b01 || head.addr[15:14] == 2'b10;
    assign imm         = !in_window || head_typ == msx_cart_pkg::CART_EMPTY;

    // writes wait out the reload cycle so the mappers see the new type first.
    assign do_write = state == ISSUE && head.wr && !reload;
    assign do_read  = state == ISSUE && !head.wr && rsv_space && (imm || mem_cnt != '0);
    assign pop      = do_write || do_read;

    assign host_credit = pop;
    assign map_addr    = head.addr;
    assign map_data    = head.data;
    assign map_wr_a    = do_write && !head.slot;
    assign map_wr_b    = do_write && head.slot;

    assign mem_req_valid = do_read && !imm;
    assign mem_req.addr  = (head.slot ? msx_cart_pkg::SLOT_SPAN : '0) + head_offset;

    assign rsv_valid = do_read;
    assign rsv_imm   = imm;
    assign rsv_data  = msx_cart_pkg::OPEN_BUS;

    assign fifo_cnt_next = fifo_cnt + msx_cart_pkg::host_cnt_t'(host_req_valid)
                         - msx_cart_pkg::host_cnt_t'(pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
            state    <= IDLE;
        end else begin
            if (host_req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt_next;
            state    <= (fifo_cnt_next != '0) ? ISSUE : IDLE; // head seen the cycle after.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_cnt <= msx_cart_pkg::mem_cnt_t'(msx_cart_pkg::MEM_CREDITS);
        end else begin
            mem_cnt <= mem_cnt - msx_cart_pkg::mem_cnt_t'(mem_req_valid)
                     + msx_cart_pkg::mem_cnt_t'(mem_credit);
        end
    end

    a_mem_credit_bound: assert property (@(posedge clk) disable iff (rst)
        mem_cnt <= msx_cart_pkg::mem_cnt_t'(msx_cart_pkg::MEM_CREDITS))
        else $error("memory credit count above its limit");

    a_intake_overflow: assert property (@(posedge clk) disable iff (rst)
        host_req_valid |-> (fifo_cnt < msx_cart_pkg::host_cnt_t'(msx_cart_pkg::HOST_CREDITS)
                            || pop))
        else $error("host request into a full intake");

endmodule

`default_nettype wire

/* msx_cart.f */
hw/msx_cart_pkg.sv
hw/cart_config.sv
hw/bank_mapper.sv
hw/slot_ctrl.sv
hw/resp_buffer.sv
hw/msx_cart_top.sv
tb/cart_checker.sv
tb/tb_msx_cart.sv

/* run_sim.sh */
#!/bin/sh
# Builds the cartridge testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_msx_cart \
    -f msx_cart.f \
    -o sim_msx_cart

./obj_dir/sim_msx_cart | tee sim.log

grep -q "^Test OK$" sim.log

/* tb/cart_checker.sv */
`default_nettype none

module cart_checker (
    input  wire                     clk,
    input  wire                     rst,
    input  msx_cart_pkg::status_t   status,
    input  wire                     disable_fdc,
    input  wire                     host_req_valid,
    input  msx_cart_pkg::host_req_t host_req,
    input  wire                     host_credit,
    input  wire                     rsp_valid,
    input  msx_cart_pkg::host_rsp_t rsp,
    input  wire                     rsp_ready,
    input  wire                     mem_req_valid,
    input  msx_cart_pkg::mem_req_t  mem_req,
    input  wire                     mem_credit,
    input  wire                     rom_a_load_hide,
    input  wire                     rom_b_load_hide,
    input  wire                     reload,
    input  wire                     hide_armed,
    input  wire                     exp_hide_a,
    input  wire                     exp_hide_b,
    output int                      errors,
    output int                      exp_left
);
    timeunit 1ns;
    timeprecision 100ps;

    int                      ref_typ [2];
    int                      latched [2];
    int                      ref_bank [2][4];
    logic [7:0]              exp_q [$];
    msx_cart_pkg::rom_addr_t addr_q [$];
    int                      mem_out;
    int                      host_avail;
    logic                    held;
    logic [7:0]              held_data;

    // 0 rom, 1 scc, 2 ascii8, 3 ascii16, 4 fdc, 5 empty.
    function automatic int decode(input int slot, input logic [3:0] sel, input logic dis);
        if (slot == 0) begin
            return (sel <= 4'd3) ? int'(sel) : 5;
        end
        if (sel == 4'd0) begin
            return dis ? 5 : 4;
        end
        return (sel <= 4'd4) ? int'(sel) - 1 : 5;
    endfunction

    // rom store address of a read, or -1 when the read is answered with open bus.
    function automatic int rom_address(input int slot, input int addr);
        int t;
        int off;
        t = ref_typ[slot];
        if (addr < 'h4000 || addr > 'hbfff || t == 5) begin
            return -1;
        end
        if (t == 1 || t == 2) begin
            off = (ref_bank[slot][(addr >> 13) - 2] % 128) * 8192 + addr % 8192;
        end else if (t == 3) begin
            off = (ref_bank[slot][(addr >> 14) - 1] % 64) * 16384 + addr % 16384;
        end else begin
            off = addr - 'h4000;
        end
        return off + slot * (1 << 20);
    endfunction

    function automatic logic [7:0] store_byte(input int ra);
        return ra[7:0] ^ ra[15:8] ^ {3'b000, ra[20:16]};
    endfunction

    task automatic apply_write(input int slot, input int addr, input int data);
        int t;
        t = ref_typ[slot];
        if (t == 1) begin
            case (addr & 'hf800)
                'h5000: ref_bank[slot][0] = data;
                'h7000: ref_bank[slot][1] = data;
                'h9000: ref_bank[slot][2] = data;
                'hb000: ref_bank[slot][3] = data;
                default: ;
            endcase
        end else if (t == 2 && addr >= 'h6000 && addr < 'h8000) begin
            ref_bank[slot][(addr - 'h6000) >> 11] = data;
        end else if (t == 3 && addr >= 'h6000 && addr < 'h6800) begin
            ref_bank[slot][0] = data;
        end else if (t == 3 && addr >= 'h7000 && addr < 'h7800) begin
            ref_bank[slot][1] = data;
        end
    endtask

    task automatic reset_banks();
        for (int s = 0; s < 2; s++) begin
            for (int b = 0; b < 4; b++) begin
                ref_bank[s][b] = b;
            end
        end
    endtask

    initial begin
        errors     = 0;
        mem_out    = 0;
        host_avail = msx_cart_pkg::HOST_CREDITS;
        held       = 1'b0;
        held_data  = 8'h00;
        reset_banks();
    end

    always @(posedge clk) begin
        logic reload_exp;
        int   read_addr;
        ref_typ[0] = decode(0, status[msx_cart_pkg::SLOT_A_LSB +: 4], disable_fdc);
        ref_typ[1] = decode(1, status[msx_cart_pkg::SLOT_B_LSB +: 4], disable_fdc);
        if (rst) begin
            latched = ref_typ;
            reset_banks();
        end else begin
            reload_exp = ref_typ[0] != latched[0] || ref_typ[1] != latched[1];
            if (reload !== reload_exp) begin
                $display("[ERROR] reload expected %h got %h", reload_exp, reload);
                errors++;
            end
            if (reload_exp) begin
                latched = ref_typ;
                reset_banks();
            end
            if (hide_armed && rom_a_load_hide !== exp_hide_a) begin
                $display("[ERROR] rom_a_load_hide expected %h got %h",
                         exp_hide_a, rom_a_load_hide);
                errors++;
            end
            if (hide_armed && rom_b_load_hide !== exp_hide_b) begin
                $display("[ERROR] rom_b_load_hide expected %h got %h",
                         exp_hide_b, rom_b_load_hide);
                errors++;
            end
            if (host_req_valid && host_avail == 0) begin
                $display("host sent a request without holding a credit");
                errors++;
            end
            host_avail = host_avail + int'(host_credit) - int'(host_req_valid);
            if (host_avail > msx_cart_pkg::HOST_CREDITS) begin
                $display("host credit returned with no request in the intake");
                errors++;
            end
            mem_out = mem_out + int'(mem_req_valid) - int'(mem_credit);
            if (mem_out > msx_cart_pkg::MEM_CREDITS || mem_out < 0) begin
                $display("memory requests outstanding out of range: %0d", mem_out);
                errors++;
            end
            if (held && (rsp_valid !== 1'b1 || rsp.data !== held_data)) begin
                $display("[ERROR] rsp.data changed while stalled, was %h now %h",
                         held_data, rsp.data);
                errors++;
            end
            if (host_req_valid && host_req.wr) begin
                apply_write(int'(host_req.slot), int'(host_req.addr), int'(host_req.data));
            end else if (host_req_valid) begin
                read_addr = rom_address(int'(host_req.slot), int'(host_req.addr));
                if (read_addr < 0) begin
                    exp_q.push_back(8'hff);
                end else begin
                    exp_q.push_back(store_byte(read_addr));
                    addr_q.push_back(msx_cart_pkg::rom_addr_t'(read_addr));
                end
            end
            if (mem_req_valid) begin
                if (addr_q.size() == 0) begin
                    $display("memory request issued with no memory read outstanding");
                    errors++;
                end else begin
                    if (mem_req.addr !== addr_q[0]) begin
                        $display("[ERROR] mem_req.addr expected %h got %h",
                                 addr_q[0], mem_req.addr);
                        errors++;
                    end
                    void'(addr_q.pop_front());
                end
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("response delivered with no read outstanding");
                    errors++;
                end else begin
                    if (rsp.data !== exp_q[0]) begin
                        $display("[ERROR] rsp.data expected %h got %h", exp_q[0], rsp.data);
                        errors++;
                    end
                    void'(exp_q.pop_front());
                end
            end
            held      = rsp_valid && !rsp_ready;
            held_data = rsp.data;
        end
        exp_left = exp_q.size();
    end

endmodule

`default_nettype wire

/* tb/cart_vectors.txt */
# cfg <sel_a> <sel_b> <disable_fdc> <hide_a> <hide_b> | wr <slot> <addr> <data>
# rd <slot> <addr> | dly <cycles>; slot 0 is slot 1, values in hex
cfg 0 0 0 0 1
rd 0 4000
rd 0 7ffe
rd 1 4000
rd 1 bfff
rd 0 c000
rd 1 2000
cfg 1 2 0 1 1
wr 0 5000 07
wr 0 7000 15
wr 0 9000 7f
wr 0 b000 85
rd 0 4123
rd 0 6123
rd 0 8123
rd 0 a123
wr 1 5000 03
rd 1 4001
cfg 2 3 0 1 1
wr 0 6000 11
wr 0 6800 22
wr 0 7000 33
wr 0 7800 44
rd 0 4000
rd 0 6000
rd 0 8000
rd 0 a000
cfg 3 4 0 1 1
wr 0 6000 05
wr 0 7000 46
rd 0 4010
rd 0 8010
cfg 3 5 0 1 1
rd 0 4010
rd 0 8010
rd 1 4000
cfg 5 0 1 1 1
rd 0 4000
rd 1 8000
cfg 0 0 1 0 1
cfg 0 0 0 0 1
rd 1 4100
rd 0 0100
rd 1 5200
rd 1 6300
rd 0 f000
rd 1 7400
dly 20
rd 0 8500

/* tb/tb_msx_cart.sv */
`default_nettype none

module tb_msx_cart;
    timeunit 1ns;
    timeprecision 100ps;

    logic                    clk = 1'b0;
    logic                    rst;
    msx_cart_pkg::status_t   status;
    logic                    disable_fdc;
    logic                    host_req_valid;
    msx_cart_pkg::host_req_t host_req;
    logic                    host_credit;
    logic                    rsp_valid;
    msx_cart_pkg::host_rsp_t rsp;
    logic                    rsp_ready;
    logic                    mem_req_valid;
    msx_cart_pkg::mem_req_t  mem_req;
    logic                    mem_credit;
    logic                    mem_rsp_valid;
    msx_cart_pkg::cpu_data_t mem_rsp_data;
    logic                    rom_a_load_hide;
    logic                    rom_b_load_hide;
    logic                    reload;
    logic                    hide_armed;
    logic                    exp_hide_a;
    logic                    exp_hide_b;
    logic                    loaded = 1'b0;
    logic [31:0]             lfsr = 32'h680c_18a4;
    int                      sent = 0;
    int                      credits_back = 0;
    int                      cyc = 0;
    int                      tb_errors = 0;
    int                      chk_errors;
    int                      exp_left;
    string                   lines [$];
    msx_cart_pkg::rom_addr_t mq_addr [$];
    int                      mq_due [$];

    msx_cart_top i_dut (.*);

    cart_checker i_checker (.*, .errors(chk_errors));

    always #2 clk = ~clk;

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0); // galois form.
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // memory requests queue up; each answers 1 to 8 cycles later, in order.
    always @(posedge clk) begin
        logic [31:0] d;
        int          due;
        cyc = cyc + 1;
        if (host_credit) credits_back++;
        if (mem_req_valid) begin
            d   = draw_bits(3);
            due = cyc + 1 + int'(d);
            if (mq_due.size() > 0 && due <= mq_due[$]) due = mq_due[$] + 1;
            mq_addr.push_back(mem_req.addr);
            mq_due.push_back(due);
        end
    end

    always @(negedge clk) begin
        logic [31:0] r;
        mem_rsp_valid = 1'b0;
        mem_credit    = 1'b0;
        if (!rst && mq_due.size() > 0 && mq_due[0] <= cyc) begin
            mem_rsp_valid = 1'b1;
            mem_credit    = 1'b1;
            mem_rsp_data  = mq_addr[0][7:0] ^ mq_addr[0][15:8] ^ {3'b000, mq_addr[0][20:16]};
            void'(mq_addr.pop_front());
            void'(mq_due.pop_front());
        end
        r = draw_bits(2);
        rsp_ready = |r[1:0]; // stalls about a quarter of the cycles.
    end

    task automatic send_req(input logic wr, input logic slot, input int addr, input int data);
        while (msx_cart_pkg::HOST_CREDITS + credits_back - sent == 0) @(negedge clk);
        host_req_valid = 1'b1;
        host_req.wr    = wr;
        host_req.slot  = slot;
        host_req.addr  = addr[15:0];
        host_req.data  = data[7:0];
        sent++;
        @(negedge clk);
        host_req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (msx_cart_pkg::HOST_CREDITS + credits_back - sent != msx_cart_pkg::HOST_CREDITS
               || exp_left != 0 || mq_due.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    task automatic run_line(input string line);
        string       cmd;
        int          a;
        int          b;
        int          c;
        int          d;
        int          e;
        logic [31:0] r;
        void'($sscanf(line, "%s %h %h %h %h %h", cmd, a, b, c, d, e));
        if (cmd == "cfg") begin
            wait_idle();
            r = draw_bits(32);
            status[63:32] = r;
            r = draw_bits(32);
            status[31:0] = r;
            status[msx_cart_pkg::SLOT_A_LSB +: 4] = a[3:0];
            status[msx_cart_pkg::SLOT_B_LSB +: 4] = b[3:0];
            disable_fdc = c[0];
            exp_hide_a  = d[0];
            exp_hide_b  = e[0];
            hide_armed  = 1'b1;
            repeat (3) @(negedge clk);
        end else if (cmd == "wr") begin
            send_req(1'b1, a[0], b, c);
        end else if (cmd == "rd") begin
            send_req(1'b0, a[0], b, 0);
        end else if (cmd == "dly") begin
            repeat (a) @(negedge clk);
        end else begin
            $display("unknown command in vector line: %s", line);
            tb_errors++;
        end
    endtask

    initial begin
        int    fd;
        string line;
        rst            = 1'b1;
        status         = '0;
        disable_fdc    = 1'b0;
        host_req_valid = 1'b0;
        host_req       = '0;
        rsp_ready      = 1'b0;
        mem_credit     = 1'b0;
        mem_rsp_valid  = 1'b0;
        mem_rsp_data   = '0;
        hide_armed     = 1'b0;
        exp_hide_a     = 1'b0;
        exp_hide_b     = 1'b0;
        fd = $fopen("tb/cart_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            tb_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") lines.push_back(line);
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (lines[i]) run_line(lines[i]);
        wait_idle();
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (lines.size() * 200 + 200) @(posedge clk);
        $display("watchdog expired before the vectors completed");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
